//--- rtl/rtc_pkg.sv
package rtc_pkg;

  //////////////////////////////////////////////////
  // Port numbers seen by the processor
  //////////////////////////////////////////////////

  // Latched RTC register address, read back on the same port
  localparam logic [7:0] port_rtc_dir      = 8'd12;
  // Bit 0 queues a read, bit 1 clears overflow
  localparam logic [7:0] port_rtc_ctrl_in  = 8'd13;
  localparam logic [7:0] port_rtc_ctrl_out = 8'd1;
  localparam logic [7:0] port_rtc_data_in  = 8'd15;
  localparam logic [7:0] port_rtc_data_out = 8'd2;
  // Same number as data_out, but write side only
  localparam logic [7:0] port_disp_sec     = 8'd2;

  // Status byte bit positions
  localparam int stat_busy     = 0;
  localparam int stat_full     = 1;
  localparam int stat_overflow = 2;
  localparam int stat_irq      = 3;
  localparam int stat_rdvalid  = 4;

  // Command fields, packed as {op, addr, wdata}
  localparam int cmd_addr_w = 8;
  localparam int cmd_data_w = 8;
  localparam int cmd_w      = 1 + cmd_addr_w + cmd_data_w;

  // Operation bit
  localparam logic op_read  = 1'b0;
  localparam logic op_write = 1'b1;

endpackage

//--- rtl/rtc_cmd_if.sv
`timescale 1ns/1ns

interface rtc_cmd_if
  import rtc_pkg::*;
();

  // Handshake
  logic                  valid;
  logic                  ready;

  // Command payload
  logic                  op;
  logic [cmd_addr_w-1:0] addr;
  logic [cmd_data_w-1:0] wdata;

  // Side that offers commands
  modport producer (
    output valid, op, addr, wdata,
    input  ready
  );

  // Side that takes commands
  modport consumer (
    input  valid, op, addr, wdata,
    output ready
  );

endinterface

//--- rtl/rtc_port_decoder.sv
`timescale 1ns/1ns

module rtc_port_decoder
  import rtc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] port_id,
  input  logic [7:0] out_port,
  input  logic       write_strobe,
  input  logic       read_strobe,
  input  logic       irq_n,
  rtc_cmd_if.producer cmd,
  input  logic [7:0] rdata,
  input  logic       rdata_valid,
  input  logic       master_busy,
  input  logic       fifo_full,
  output logic [7:0] in_port,
  output logic [7:0] disp_sec
);

  logic [cmd_addr_w-1:0] addr_reg;
  logic [7:0]            rd_byte;
  logic                  overflow;
  logic                  rdvalid;
  logic [1:0]            irq_sync;
  logic [7:0]            status;
  logic                  wr_data;
  logic                  wr_ctrl;
  logic                  new_cmd;
  logic                  held;

  //////////////////////////////////////////////////
  // Port write decode
  //////////////////////////////////////////////////

  assign wr_data = write_strobe && (port_id == port_rtc_data_in);
  assign wr_ctrl = write_strobe && (port_id == port_rtc_ctrl_in);
  // Data write or read request
  assign new_cmd = wr_data || (wr_ctrl && out_port[0]);
  // Command still waiting on the FIFO
  assign held    = cmd.valid && !cmd.ready;

  // Address and display registers
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      addr_reg <= '0;
      disp_sec <= 8'h66;
    end
    else
    begin
      if (write_strobe && port_id == port_rtc_dir)
        addr_reg <= out_port;
      if (write_strobe && port_id == port_disp_sec)
        disp_sec <= out_port;
    end
  end

  // Held command, dropped when the slot is still occupied
  always_ff @(posedge clk)
  begin
    if (reset)
      cmd.valid <= 1'b0;
    else if (new_cmd && !held)
      cmd.valid <= 1'b1;
    else if (cmd.ready)
      cmd.valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (new_cmd && !held)
    begin
      cmd.op    <= wr_data ? op_write : op_read;
      cmd.addr  <= addr_reg;
      cmd.wdata <= wr_data ? out_port : 8'h00;
    end
  end

  //////////////////////////////////////////////////
  // Status flags
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      overflow <= 1'b0;
      rdvalid  <= 1'b0;
      irq_sync <= 2'b11;
    end
    else
    begin
      // Set wins over a clear in the same cycle
      if (new_cmd && held)
        overflow <= 1'b1;
      else if (wr_ctrl && out_port[1])
        overflow <= 1'b0;
      if (rdata_valid)
        rdvalid <= 1'b1;
      else if (read_strobe && port_id == port_rtc_data_out)
        rdvalid <= 1'b0;
      // Two-flop sync of the chip IRQ
      irq_sync <= {irq_sync[0], irq_n};
    end
  end

  // Last byte returned by the bus master
  always_ff @(posedge clk)
  begin
    if (rdata_valid)
      rd_byte <= rdata;
  end

  always_comb
  begin
    status                = '0;
    status[stat_busy]     = cmd.valid || master_busy;
    status[stat_full]     = fifo_full;
    status[stat_overflow] = overflow;
    status[stat_irq]      = ~irq_sync[1];
    status[stat_rdvalid]  = rdvalid;
  end

  // Registered input port mux
  always_ff @(posedge clk)
  begin
    if (reset)
      in_port <= '0;
    else
      case (port_id)
        port_rtc_dir:      in_port <= addr_reg;
        port_rtc_ctrl_out: in_port <= status;
        port_rtc_data_out: in_port <= rd_byte;
        default:           in_port <= '0;
      endcase
  end

  // Fields of a waiting command must not move until the FIFO takes it
  a_held_stable: assert property (@(posedge clk) disable iff (reset)
    cmd.valid && !cmd.ready |=> cmd.valid && $stable({cmd.op, cmd.addr, cmd.wdata}));

endmodule

//--- rtl/rtc_cmd_fifo.sv
`timescale 1ns/1ns

module rtc_cmd_fifo
  import rtc_pkg::*;
#(
  parameter int fifo_depth = 4
)
(
  input  logic        clk,
  input  logic        reset,
  rtc_cmd_if.consumer wr,
  rtc_cmd_if.producer rd,
  output logic        full
);

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

  logic [cmd_w-1:0] mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             push;
  logic             pop;

  assign full     = (count == (ptr_w+1)'(fifo_depth));
  assign wr.ready = !full;
  assign push     = wr.valid && wr.ready;
  assign pop      = rd.valid && rd.ready;

  // Head entry shows as soon as it is stored
  assign rd.valid = (count != '0);
  assign {rd.op, rd.addr, rd.wdata} = mem[rd_ptr];

  //////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= {wr.op, wr.addr, wr.wdata};
  end

  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  a_count_max: assert property (@(posedge clk) disable iff (reset)
    count <= (ptr_w+1)'(fifo_depth));

  // Full FIFO with no pop leaves the write side untouched next cycle
  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    full && !pop |=> $stable(wr_ptr) && full);

endmodule

//--- rtl/rtc_bus_master.sv
`timescale 1ns/1ns

module rtc_bus_master
  import rtc_pkg::*;
#(
  // At least 2, the write strobe needs a release cycle
  parameter int phase_cycles = 2
)
(
  input  logic        clk,
  input  logic        reset,
  rtc_cmd_if.consumer cmd,
  output logic        cs_n,
  output logic        ad_n,
  output logic        rd_n,
  output logic        wr_n,
  output logic [7:0]  bus_out,
  output logic        bus_oe,
  input  logic [7:0]  bus_in,
  output logic [7:0]  rdata,
  output logic        rdata_valid,
  output logic        busy
);

  localparam int cnt_w = $clog2(phase_cycles + 1);

  // FSM states
  localparam logic [1:0] st_idle    = 2'd0;
  localparam logic [1:0] st_addr    = 2'd1;
  localparam logic [1:0] st_data    = 2'd2;
  localparam logic [1:0] st_recover = 2'd3;

  logic [1:0]            state;
  logic [cnt_w-1:0]      phase_cnt;
  logic                  last;
  logic                  op_q;
  logic [cmd_addr_w-1:0] addr_q;
  logic [cmd_data_w-1:0] wdata_q;

  assign last      = (phase_cnt == cnt_w'(phase_cycles - 1));
  assign cmd.ready = (state == st_idle);
  // Pending work at the input also counts as busy
  assign busy      = (state != st_idle) || cmd.valid;

  //////////////////////////////////////////////////
  // Phase sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= st_idle;
      phase_cnt <= '0;
    end
    else
      case (state)
        st_idle:
          if (cmd.valid)
          begin
            state     <= st_addr;
            phase_cnt <= '0;
          end
        st_addr, st_data:
          if (last)
          begin
            state     <= (state == st_addr) ? st_data : st_recover;
            phase_cnt <= '0;
          end
          else
            phase_cnt <= phase_cnt + 1'b1;
        default:
          state <= st_idle;
      endcase
  end

  // Command capture and read sampling
  always_ff @(posedge clk)
  begin
    if (cmd.valid && cmd.ready)
    begin
      op_q    <= cmd.op;
      addr_q  <= cmd.addr;
      wdata_q <= cmd.wdata;
    end
    // Sample on the last data cycle, chip still driving
    if (state == st_data && last && op_q == op_read)
      rdata <= bus_in;
  end

  //////////////////////////////////////////////////
  // Chip strobes
  //////////////////////////////////////////////////

  assign cs_n = !(state == st_addr || state == st_data);
  assign ad_n = (state != st_addr);
  // Write strobe rises on the last phase cycle, bus and ad_n still stable
  assign wr_n = !((state == st_addr || (state == st_data && op_q == op_write)) && !last);
  assign rd_n = !(state == st_data && op_q == op_read);
  assign bus_oe  = (state == st_addr) || (state == st_data && op_q == op_write);
  assign bus_out = (state == st_data) ? wdata_q : addr_q;

  // Read byte handed back on the recovery cycle
  assign rdata_valid = (state == st_recover) && (op_q == op_read);

  a_strobe_excl: assert property (@(posedge clk) disable iff (reset)
    state == st_data |-> rd_n || wr_n);

  a_no_drive_on_read: assert property (@(posedge clk) disable iff (reset)
    !rd_n |-> !bus_oe);

  // Accepted read returns its byte a fixed time later
  a_read_latency: assert property (@(posedge clk) disable iff (reset)
    cmd.valid && cmd.ready && cmd.op == op_read |-> ##(2*phase_cycles+1) rdata_valid);

endmodule

//--- rtl/rtc_io_top.sv
`timescale 1ns/1ns

module rtc_io_top #(
  parameter int fifo_depth   = 4,
  parameter int phase_cycles = 2
)
(
  input  logic       clk,
  input  logic       reset,
  // Processor port side
  input  logic [7:0] port_id,
  input  logic [7:0] out_port,
  input  logic       write_strobe,
  input  logic       read_strobe,
  input  logic       irq_n,
  output logic [7:0] in_port,
  output logic [7:0] disp_sec,
  // RTC chip side, active low strobes
  output logic       cs_n,
  output logic       ad_n,
  output logic       rd_n,
  output logic       wr_n,
  output logic [7:0] bus_out,
  output logic       bus_oe,
  input  logic [7:0] bus_in
);

  logic [7:0] rdata;
  logic       rdata_valid;
  logic       master_busy;
  logic       fifo_full;

  // Decoder to FIFO, FIFO to bus master
  rtc_cmd_if cmd_in ();
  rtc_cmd_if cmd_out ();

  rtc_port_decoder u_decoder (
    .clk          (clk),
    .reset        (reset),
    .port_id      (port_id),
    .out_port     (out_port),
    .write_strobe (write_strobe),
    .read_strobe  (read_strobe),
    .irq_n        (irq_n),
    .cmd          (cmd_in.producer),
    .rdata        (rdata),
    .rdata_valid  (rdata_valid),
    .master_busy  (master_busy),
    .fifo_full    (fifo_full),
    .in_port      (in_port),
    .disp_sec     (disp_sec)
  );

  rtc_cmd_fifo #(
    .fifo_depth (fifo_depth)
  ) u_fifo (
    .clk   (clk),
    .reset (reset),
    .wr    (cmd_in.consumer),
    .rd    (cmd_out.producer),
    .full  (fifo_full)
  );

  rtc_bus_master #(
    .phase_cycles (phase_cycles)
  ) u_master (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd_out.consumer),
    .cs_n        (cs_n),
    .ad_n        (ad_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .bus_out     (bus_out),
    .bus_oe      (bus_oe),
    .bus_in      (bus_in),
    .rdata       (rdata),
    .rdata_valid (rdata_valid),
    .busy        (master_busy)
  );

endmodule

//--- tb/rtc_chip_model.sv
`timescale 1ns/1ns

module rtc_chip_model (
  input  logic       cs_n,
  input  logic       ad_n,
  input  logic       rd_n,
  input  logic       wr_n,
  input  logic [7:0] bus_out,
  input  logic       bus_oe,
  output logic [7:0] bus_in,
  output int         write_count,
  output logic [7:0] last_addr,
  output logic [7:0] last_data
);

  logic [7:0] regs [256];
  logic [7:0] addr_q;
  logic [7:0] bus;

  // Shared AD bus as the chip sees it, floats high when nobody drives
  assign bus    = bus_oe ? bus_out : 8'hff;
  // Chip drives the addressed register while RD is low
  assign bus_in = (!cs_n && !rd_n) ? regs[addr_q] : 8'hff;

  initial
  begin
    // Power-up contents, every address distinct
    for (int i = 0; i < 256; i++)
      regs[i] = 8'(i * 29) ^ 8'hc3;
    addr_q      = 8'h00;
    write_count = 0;
    last_addr   = 8'h00;
    last_data   = 8'h00;
  end

  // WR rising edge latches address or data, chosen by AD
  always @(posedge wr_n)
  begin
    if (!cs_n)
    begin
      if (!ad_n)
        addr_q <= bus;
      else
      begin
        regs[addr_q] <= bus;
        last_addr    <= addr_q;
        last_data    <= bus;
        write_count  <= write_count + 1;
      end
    end
  end

endmodule

//--- tb/tb_rtc_io.sv
`timescale 1ns/1ns

module tb_rtc_io
  import rtc_pkg::*;
();

  localparam int fifo_depth   = 4;
  localparam int phase_cycles = 2;
  localparam int n_rand       = 8;
  localparam int burst_len    = fifo_depth + 4;
  // Bus commands over the whole run
  localparam int num_cmds     = 2 * n_rand + (fifo_depth + 2) + burst_len;
  localparam int txn_cycles   = 2 * phase_cycles + 1;
  localparam int watchdog_cycles = num_cmds * (txn_cycles + 10) + 200;

  logic       clk;
  logic       reset;
  logic [7:0] port_id;
  logic [7:0] out_port;
  logic       write_strobe;
  logic       read_strobe;
  logic       irq_n;
  logic [7:0] in_port;
  logic [7:0] disp_sec;
  logic       cs_n;
  logic       ad_n;
  logic       rd_n;
  logic       wr_n;
  logic [7:0] bus_out;
  logic       bus_oe;
  logic [7:0] bus_in;
  int         chip_writes;
  logic [7:0] chip_addr;
  logic [7:0] chip_data;

  // Reference copy of the chip registers
  logic [7:0] ref_mem [256];
  // Writes still owed to the chip, oldest first
  logic [7:0] exp_addr [$];
  logic [7:0] exp_data [$];
  logic [7:0] exp_a;
  logic [7:0] exp_d;
  int         writes_seen;
  int         errors;

  always #20 clk = ~clk;

  rtc_io_top #(
    .fifo_depth   (fifo_depth),
    .phase_cycles (phase_cycles)
  ) u_rtc_io_top (
    .clk          (clk),
    .reset        (reset),
    .port_id      (port_id),
    .out_port     (out_port),
    .write_strobe (write_strobe),
    .read_strobe  (read_strobe),
    .irq_n        (irq_n),
    .in_port      (in_port),
    .disp_sec     (disp_sec),
    .cs_n         (cs_n),
    .ad_n         (ad_n),
    .rd_n         (rd_n),
    .wr_n         (wr_n),
    .bus_out      (bus_out),
    .bus_oe       (bus_oe),
    .bus_in       (bus_in)
  );

  rtc_chip_model u_chip (
    .cs_n        (cs_n),
    .ad_n        (ad_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .bus_out     (bus_out),
    .bus_oe      (bus_oe),
    .bus_in      (bus_in),
    .write_count (chip_writes),
    .last_addr   (chip_addr),
    .last_data   (chip_data)
  );

  //////////////////////////////////////////////////
  // Reference model and helpers
  //////////////////////////////////////////////////

  // Applies a write, returns the byte a read should see
  function automatic logic [7:0] rtc_expect(input logic is_write, input logic [7:0] addr,
                                            input logic [7:0] data);
    if (is_write)
      ref_mem[addr] = data;
    return ref_mem[addr];
  endfunction

  task automatic log_error(input string msg);
    errors++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  task automatic queue_expected_write(input logic [7:0] addr, input logic [7:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    void'(rtc_expect(1'b1, addr, data));
  endtask

  // Entered 2 ns after a rising edge, strobe high for exactly one edge
  task automatic port_write(input logic [7:0] id, input logic [7:0] data);
    port_id      = id;
    out_port     = data;
    write_strobe = 1'b1;
    @(posedge clk);
    #2;
    write_strobe = 1'b0;
  endtask

  // in_port registered on the strobe edge
  task automatic port_read(input logic [7:0] id, output logic [7:0] data);
    port_id     = id;
    read_strobe = 1'b1;
    @(posedge clk);
    #2;
    read_strobe = 1'b0;
    data        = in_port;
  endtask

  // Poll status until busy drops, then all owed writes must be in
  task automatic wait_idle();
    logic [7:0] stat;
    int         polls;
    stat  = 8'hff;
    polls = 0;
    while (stat[stat_busy] && polls < 100)
    begin
      port_read(port_rtc_ctrl_out, stat);
      polls++;
    end
    if (stat[stat_busy])
    begin
      errors++;
      $display("RTC interface still busy after %0d status polls", polls);
    end
    if (exp_addr.size() != 0)
    begin
      errors++;
      $display("%0d expected chip writes never reached the chip", exp_addr.size());
      exp_addr.delete();
      exp_data.delete();
    end
  endtask

  task automatic wait_rdvalid();
    logic [7:0] stat;
    int         polls;
    stat  = 8'h00;
    polls = 0;
    while (!stat[stat_rdvalid] && polls < 50)
    begin
      port_read(port_rtc_ctrl_out, stat);
      polls++;
    end
    if (!stat[stat_rdvalid])
    begin
      errors++;
      $display("Read byte never flagged in status after %0d polls", polls);
    end
  endtask

  // Comparator, chip outputs settle well before the falling edge
  always @(negedge clk)
  begin
    if (!reset && chip_writes != writes_seen)
    begin
      writes_seen = writes_seen + 1;
      if (exp_addr.size() == 0)
        log_error($sformatf("unexpected chip write addr %02h data %02h", chip_addr, chip_data));
      else
      begin
        exp_a = exp_addr.pop_front();
        exp_d = exp_data.pop_front();
        if (chip_addr !== exp_a || chip_data !== exp_d)
          log_error($sformatf("chip write %02h:%02h, expected %02h:%02h",
                              chip_addr, chip_data, exp_a, exp_d));
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////

  task automatic check_reset_state();
    logic [7:0] stat;
    if (cs_n !== 1'b1 || ad_n !== 1'b1 || rd_n !== 1'b1 || wr_n !== 1'b1)
      log_error($sformatf("strobes cs_n=%b ad_n=%b rd_n=%b wr_n=%b after reset",
                          cs_n, ad_n, rd_n, wr_n));
    if (bus_oe !== 1'b0)
      log_error("bus_oe high after reset");
    if (disp_sec !== 8'h66)
      log_error($sformatf("disp_sec %02h after reset, expected 66", disp_sec));
    port_read(port_rtc_ctrl_out, stat);
    if (stat !== 8'h00)
      log_error($sformatf("status %02h after reset, expected 00", stat));
  endtask

  task automatic write_read_random();
    logic [7:0] addrs [n_rand];
    logic [7:0] data;
    logic [7:0] got;
    logic [7:0] expected;
    for (int i = 0; i < n_rand; i++)
    begin
      addrs[i] = 8'($urandom);
      data     = 8'($urandom);
      port_write(port_rtc_dir, addrs[i]);
      port_write(port_rtc_data_in, data);
      queue_expected_write(addrs[i], data);
      wait_idle();
    end
    for (int i = 0; i < n_rand; i++)
    begin
      port_write(port_rtc_dir, addrs[i]);
      port_write(port_rtc_ctrl_in, 8'h01);
      wait_rdvalid();
      port_read(port_rtc_data_out, got);
      expected = rtc_expect(1'b0, addrs[i], 8'h00);
      if (got !== expected)
        log_error($sformatf("read addr %02h got %02h, expected %02h", addrs[i], got, expected));
    end
    wait_idle();
  endtask

  // Decoder slot, FIFO and master together hold fifo_depth+2 commands
  task automatic back_to_back_writes();
    logic [7:0] addr;
    logic [7:0] data;
    logic [7:0] stat;
    addr = 8'($urandom);
    port_write(port_rtc_dir, addr);
    for (int i = 0; i < fifo_depth + 2; i++)
    begin
      data = 8'($urandom);
      port_write(port_rtc_data_in, data);
      queue_expected_write(addr, data);
    end
    wait_idle();
    port_read(port_rtc_ctrl_out, stat);
    if (stat[stat_overflow])
      log_error("overflow set by a burst that fits the buffering");
  endtask

  task automatic overflow_and_clear();
    logic [7:0] addr;
    logic [7:0] data;
    logic [7:0] stat;
    addr = 8'($urandom);
    port_write(port_rtc_dir, addr);
    for (int i = 0; i < burst_len; i++)
    begin
      data = 8'($urandom);
      port_write(port_rtc_data_in, data);
      // Later ones find the slot still held and drop
      if (i < fifo_depth + 2)
        queue_expected_write(addr, data);
    end
    port_read(port_rtc_ctrl_out, stat);
    if (!stat[stat_overflow])
      log_error($sformatf("status %02h after overrun, overflow not set", stat));
    // FIFO still packed, master only just back to idle
    if (!stat[stat_full])
      log_error($sformatf("status %02h after overrun, full not set", stat));
    wait_idle();
    port_write(port_rtc_ctrl_in, 8'h02);
    port_read(port_rtc_ctrl_out, stat);
    if (stat[stat_overflow])
      log_error("overflow still set after clear");
  endtask

  task automatic display_and_dir();
    logic [7:0] sec;
    logic [7:0] addr;
    logic [7:0] got;
    sec = 8'($urandom);
    port_write(port_disp_sec, sec);
    if (disp_sec !== sec)
      log_error($sformatf("disp_sec %02h, expected %02h", disp_sec, sec));
    addr = 8'($urandom);
    port_write(port_rtc_dir, addr);
    port_read(port_rtc_dir, got);
    if (got !== addr)
      log_error($sformatf("address readback %02h, expected %02h", got, addr));
  endtask

  // Two sync flops plus the registered read, three reads at most
  task automatic irq_follow();
    logic [7:0] stat;
    int         reads;
    irq_n = 1'b0;
    stat  = 8'h00;
    reads = 0;
    while (!stat[stat_irq] && reads < 3)
    begin
      port_read(port_rtc_ctrl_out, stat);
      reads++;
    end
    if (!stat[stat_irq])
      log_error("stat_irq not set within three cycles of irq_n low");
    irq_n = 1'b1;
    reads = 0;
    while (stat[stat_irq] && reads < 3)
    begin
      port_read(port_rtc_ctrl_out, stat);
      reads++;
    end
    if (stat[stat_irq])
      log_error("stat_irq still set three cycles after irq_n release");
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////

  initial
  begin
    clk          = 1'b0;
    reset        = 1'b1;
    port_id      = 8'h00;
    out_port     = 8'h00;
    write_strobe = 1'b0;
    read_strobe  = 1'b0;
    irq_n        = 1'b1;
    errors       = 0;
    writes_seen  = 0;
    void'($urandom(10161));
    // Same power-up contents as the chip
    for (int i = 0; i < 256; i++)
      ref_mem[i] = 8'(i * 29) ^ 8'hc3;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    check_reset_state();
    write_read_random();
    back_to_back_writes();
    overflow_and_clear();
    display_and_dir();
    irq_follow();
    $display("Run complete, errors: %0d", errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- compile.f
rtl/rtc_pkg.sv
rtl/rtc_cmd_if.sv
rtl/rtc_port_decoder.sv
rtl/rtc_cmd_fifo.sv
rtl/rtc_bus_master.sv
rtl/rtc_io_top.sv
tb/rtc_chip_model.sv
tb/tb_rtc_io.sv

//--- Makefile
# Verilator build of the RTC port I/O testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rtc_io
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
